/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_pkt_gen
FILELIST  ?= pkt_gen_top.f
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

# the run passes only if the pass line shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -qF '>>> PASS'

clean:
	rm -rf $(OBJ_DIR)

/* eth_frame_pkg.sv */
/*
  Ethernet frame format on the transmit wire.
  Lane and beat geometry, header field widths and the transmit beat.
*/
`default_nettype none

package eth_frame_pkg;

  // ------------------------------------------------------------------------
  // beat geometry
  // ------------------------------------------------------------------------
  localparam int LANES      = 4;            // 64-bit lanes per beat
  localparam int LANE_W     = 64;
  localparam int BEAT_BYTES = LANES * LANE_W / 8;
  localparam int EMPTY_W    = 5;            // also log2 of BEAT_BYTES

  // ------------------------------------------------------------------------
  // header and payload
  // ------------------------------------------------------------------------
  localparam int MAC_W         = 48;
  localparam int SIZE_W        = 14;        // packet size in bytes
  localparam int MIN_PKT_BYTES = 64;

  localparam logic [7:0] FIXED_BYTE = 8'hA5; // fixed payload pattern

  // one lane, first byte on the wire in bits [63:56]
  typedef logic [LANE_W-1:0] lane_t;

  // transmit beat
  // lane 0 is the most significant lane and carries the earliest bytes
  typedef struct packed {
    logic                 valid;
    logic                 sop;
    logic                 eop;
    logic [EMPTY_W-1:0]   empty;  // unused bytes at the end of an eop beat
    lane_t [0:LANES-1]    data;
  } tx_beat_t;

endpackage : eth_frame_pkg

`default_nettype wire

/* lane_pattern_gen.sv */
/*
  Lane pattern generator. Builds one 64-bit lane of a beat from the
  header fields on sop, or from the payload pattern otherwise.
*/
`default_nettype none

module lane_pattern_gen #(
  parameter int LANE = 0     // lane position, 0 is the first on the wire
) (
  input  wire pkt_gen_cfg_pkg::beat_ctl_t           i_ctl,
  input  wire logic [eth_frame_pkg::MAC_W-1:0]      i_dmac,
  input  wire logic [eth_frame_pkg::MAC_W-1:0]      i_smac,
  input  wire pkt_gen_cfg_pkg::pattern_e            i_pattern,
  output eth_frame_pkg::lane_t                      o_lane
);

  localparam int LANE_BYTES = eth_frame_pkg::LANE_W / 8;

  logic [7:0]           lane_base;  // offset of this lane's first byte, mod 256
  eth_frame_pkg::lane_t payload;

  assign lane_base = 8'(i_ctl.beat_idx * eth_frame_pkg::BEAT_BYTES + LANE * LANE_BYTES);

  // payload bytes, first byte in the top of the lane
  always_comb begin
    for (int b = 0; b < LANE_BYTES; b++) begin
      if (i_pattern == pkt_gen_cfg_pkg::PAT_FIXED) begin
        payload[eth_frame_pkg::LANE_W-1-8*b -: 8] = eth_frame_pkg::FIXED_BYTE;
      end else begin
        payload[eth_frame_pkg::LANE_W-1-8*b -: 8] = lane_base + 8'(b);
      end
    end
  end

  // ------------------------------------------------------------------------
  // header overlay on the first beat
  // ------------------------------------------------------------------------
  always_comb begin
    o_lane = payload;
    if (i_ctl.sop) begin
      case (LANE)
        0: o_lane = {i_dmac, i_smac[eth_frame_pkg::MAC_W-1 -: 16]};
        1: o_lane = {i_smac[eth_frame_pkg::MAC_W-17:0],    // low 32 source bits
                     16'(i_ctl.size),
                     i_ctl.pkt_idx};
        default: o_lane = payload;  // lanes past the header
      endcase
    end
  end

endmodule : lane_pattern_gen

`default_nettype wire

/* pkt_gen_cfg_pkg.sv */
/*
  Packet generator control definitions.
  Run configuration, pattern and state encodings, beat control and stats.
*/
`default_nettype none

package pkt_gen_cfg_pkg;

  // cycles between i_tx_ready and the beat it allows
  localparam int READY_LATENCY = 2;

  localparam int BEAT_IDX_W = 9;   // enough for the largest size
  localparam int PKT_IDX_W  = 16;

  // ------------------------------------------------------------------------
  // encodings
  // ------------------------------------------------------------------------
  typedef enum logic {
    PAT_INCR  = 1'b0,   // byte equals its offset mod 256
    PAT_FIXED = 1'b1
  } pattern_e;

  typedef enum logic [1:0] {
    S_IDLE = 2'd0,
    S_SEND = 2'd1,
    S_GAP  = 2'd2
  } seq_state_e;

  // ------------------------------------------------------------------------
  // structs
  // ------------------------------------------------------------------------
  // held stable for the whole run
  typedef struct packed {
    logic [eth_frame_pkg::MAC_W-1:0]  dmac;
    logic [eth_frame_pkg::MAC_W-1:0]  smac;
    logic [eth_frame_pkg::SIZE_W-1:0] start_size;
    logic [eth_frame_pkg::SIZE_W-1:0] end_size;
    logic [31:0]                      pkt_num;
    logic                             cont_mode;   // run until stop strobe
    logic [7:0]                       ipg_cycles;
    pattern_e                         pattern;
  } pkt_cfg_t;

  // sequencer to lanes and drain
  typedef struct packed {
    logic                             valid;
    logic                             sop;
    logic                             eop;
    logic [BEAT_IDX_W-1:0]            beat_idx;   // beat within the packet
    logic [PKT_IDX_W-1:0]             pkt_idx;    // packet within the run
    logic [eth_frame_pkg::SIZE_W-1:0] size;       // bytes in this packet
  } beat_ctl_t;

  typedef struct packed {
    logic [15:0] sop_cnt;
    logic [15:0] eop_cnt;
    logic [31:0] byte_cnt;
  } tx_stats_t;

endpackage : pkt_gen_cfg_pkg

`default_nettype wire

/* pkt_gen_top.f */
+incdir+.
eth_frame_pkg.sv
pkt_gen_cfg_pkg.sv
pkt_sequencer.sv
lane_pattern_gen.sv
tx_beat_drain.sv
pkt_gen_top.sv
tb_pkt_gen.sv

/* pkt_gen_top.sv */
/*
  Ethernet test-packet generator, top level.
  Sequencer, one pattern generator per lane and the beat drain.
*/
`default_nettype none

module pkt_gen_top (
  input  wire logic                       i_clk_tx,
  input  wire logic                       i_reset,
  input  wire pkt_gen_cfg_pkg::pkt_cfg_t  i_cfg,
  input  wire logic                       i_start,
  input  wire logic                       i_stop,
  input  wire logic                       i_stat_clr,
  input  wire logic                       i_tx_ready,
  output eth_frame_pkg::tx_beat_t         o_tx,
  output logic                            o_busy,
  output pkt_gen_cfg_pkg::tx_stats_t      o_stats
);

  pkt_gen_cfg_pkg::beat_ctl_t                   ctl;
  eth_frame_pkg::lane_t [0:eth_frame_pkg::LANES-1] lanes;

  pkt_sequencer u_seq (
    .i_clk_tx   (i_clk_tx),
    .i_reset    (i_reset),
    .i_cfg      (i_cfg),
    .i_start    (i_start),
    .i_stop     (i_stop),
    .i_tx_ready (i_tx_ready),
    .o_ctl      (ctl),
    .o_busy     (o_busy)
  );

  for (genvar g = 0; g < eth_frame_pkg::LANES; g++) begin : g_lane
    lane_pattern_gen #(.LANE(g)) u_lane (
      .i_ctl     (ctl),
      .i_dmac    (i_cfg.dmac),
      .i_smac    (i_cfg.smac),
      .i_pattern (i_cfg.pattern),
      .o_lane    (lanes[g])
    );
  end

  tx_beat_drain u_drain (
    .i_clk_tx   (i_clk_tx),
    .i_reset    (i_reset),
    .i_ctl      (ctl),
    .i_lanes    (lanes),
    .i_stat_clr (i_stat_clr),
    .o_tx       (o_tx),
    .o_stats    (o_stats)
  );

endmodule : pkt_gen_top

`default_nettype wire

/* pkt_sequencer.sv */
/*
  Packet sequencer. Paces packets, sizes, beats and inter-packet gaps,
  offering one beat per delayed transmit ready slot.
*/
`default_nettype none

module pkt_sequencer (
  input  wire logic                       i_clk_tx,
  input  wire logic                       i_reset,
  input  wire pkt_gen_cfg_pkg::pkt_cfg_t  i_cfg,
  input  wire logic                       i_start,
  input  wire logic                       i_stop,
  input  wire logic                       i_tx_ready,
  output pkt_gen_cfg_pkg::beat_ctl_t      o_ctl,
  output logic                            o_busy
);

  logic [pkt_gen_cfg_pkg::READY_LATENCY-1:0] rdy_sr;  // ready history
  logic                                      slot;

  pkt_gen_cfg_pkg::seq_state_e                state;
  logic [eth_frame_pkg::SIZE_W-1:0]           size;
  logic [eth_frame_pkg::SIZE_W-1:0]           size_m1;
  logic [pkt_gen_cfg_pkg::BEAT_IDX_W-1:0]     beat_idx;
  logic [31:0]                                pkt_cnt;   // packets done this run
  logic [7:0]                                 gap_cnt;
  logic                                       stop_req;
  logic                                       offer;
  logic                                       last_beat;
  logic                                       run_done;

  // ------------------------------------------------------------------------
  // ready latency
  // ------------------------------------------------------------------------
  always_ff @(posedge i_clk_tx) begin
    if (i_reset) begin
      rdy_sr <= '0;
    end else begin
      rdy_sr <= {rdy_sr[pkt_gen_cfg_pkg::READY_LATENCY-2:0], i_tx_ready};
    end
  end

  assign slot = rdy_sr[pkt_gen_cfg_pkg::READY_LATENCY-1];

  // ------------------------------------------------------------------------
  // beat and packet control
  // ------------------------------------------------------------------------
  assign size_m1   = size - 1'b1;
  assign last_beat = (beat_idx == size_m1[eth_frame_pkg::SIZE_W-1:eth_frame_pkg::EMPTY_W]);
  assign offer     = (state == pkt_gen_cfg_pkg::S_SEND) && slot;
  assign run_done  = i_cfg.cont_mode ? (stop_req | i_stop)
                                     : (pkt_cnt + 32'd1 == i_cfg.pkt_num);

  always_ff @(posedge i_clk_tx) begin
    if (i_reset) begin
      state    <= pkt_gen_cfg_pkg::S_IDLE;
      beat_idx <= '0;
      pkt_cnt  <= '0;
      gap_cnt  <= '0;
      stop_req <= 1'b0;
    end else begin
      case (state)
        pkt_gen_cfg_pkg::S_IDLE: begin
          beat_idx <= '0;
          stop_req <= 1'b0;
          if (i_start) begin
            pkt_cnt <= '0;
            state   <= pkt_gen_cfg_pkg::S_SEND;
          end
        end
        pkt_gen_cfg_pkg::S_SEND: begin
          if (i_stop) stop_req <= 1'b1;
          if (offer && !last_beat) begin
            beat_idx <= beat_idx + 1'b1;
          end else if (offer) begin       // eop beat goes out
            beat_idx <= '0;
            pkt_cnt  <= pkt_cnt + 32'd1;
            gap_cnt  <= i_cfg.ipg_cycles;
            if (run_done) begin
              state <= pkt_gen_cfg_pkg::S_IDLE;
            end else if (i_cfg.ipg_cycles != 8'd0) begin
              state <= pkt_gen_cfg_pkg::S_GAP;
            end
          end
        end
        pkt_gen_cfg_pkg::S_GAP: begin
          if (i_stop) stop_req <= 1'b1;
          gap_cnt <= gap_cnt - 8'd1;      // runs whatever ready does
          if (i_cfg.cont_mode && (stop_req || i_stop)) begin
            state <= pkt_gen_cfg_pkg::S_IDLE;
          end else if (gap_cnt == 8'd1) begin
            state <= pkt_gen_cfg_pkg::S_SEND;
          end
        end
        default: state <= pkt_gen_cfg_pkg::S_IDLE;
      endcase
    end
  end

  // size sweep, wraps end_size back to start_size
  always_ff @(posedge i_clk_tx) begin
    if (state == pkt_gen_cfg_pkg::S_IDLE) begin
      size <= i_cfg.start_size;
    end else if (offer && last_beat) begin
      size <= (size == i_cfg.end_size) ? i_cfg.start_size : size + 1'b1;
    end
  end

  assign o_ctl = '{
    valid:    offer,
    sop:      offer && (beat_idx == '0),
    eop:      offer && last_beat,
    beat_idx: beat_idx,
    pkt_idx:  pkt_cnt[pkt_gen_cfg_pkg::PKT_IDX_W-1:0],
    size:     size
  };

  assign o_busy = (state != pkt_gen_cfg_pkg::S_IDLE);

  // ------------------------------------------------------------------------
  // checks
  // ------------------------------------------------------------------------
  a_valid_in_slot: assert property (@(posedge i_clk_tx) disable iff (i_reset)
    o_ctl.valid |-> $past(i_tx_ready, pkt_gen_cfg_pkg::READY_LATENCY));

  a_eop_with_valid: assert property (@(posedge i_clk_tx) disable iff (i_reset)
    o_ctl.eop |-> o_ctl.valid && o_busy);

  // sweep range must be sane when a run begins
  a_start_sizes: assert property (@(posedge i_clk_tx) disable iff (i_reset)
    (i_start && state == pkt_gen_cfg_pkg::S_IDLE) |->
      (i_cfg.start_size <= i_cfg.end_size) &&
      (i_cfg.start_size >= eth_frame_pkg::SIZE_W'(eth_frame_pkg::MIN_PKT_BYTES)));

endmodule : pkt_sequencer

`default_nettype wire

/* tb_pkt_gen_tests.svh */
/*
  Directed tests for the packet generator testbench.
  Each test sets a run config, strobes start and checks the outcome.
*/

// fixed addresses for every run
function automatic pkt_gen_cfg_pkg::pkt_cfg_t make_cfg(int first, int last, int num,
    logic cont, int ipg, pkt_gen_cfg_pkg::pattern_e pat);
  pkt_gen_cfg_pkg::pkt_cfg_t c;
  c.dmac       = 48'h02_1A_2B_3C_4D_5E;
  c.smac       = 48'h02_F0_E1_D2_C3_B4;
  c.start_size = 14'(first);
  c.end_size   = 14'(last);
  c.pkt_num    = 32'(num);
  c.cont_mode  = cont;
  c.ipg_cycles = 8'(ipg);
  c.pattern    = pat;
  return c;
endfunction

// ------------------------------------------------------------------------
// stimulus helpers
// ------------------------------------------------------------------------
task automatic start_run(pkt_gen_cfg_pkg::pkt_cfg_t c);
  @(posedge clk);
  cfg <= c;                 // settles a cycle before start
  @(posedge clk);
  start <= 1'b1;
  @(posedge clk);
  start <= 1'b0;
endtask

task automatic wait_frames(int n);
  do @(negedge clk); while (run_frames < n);
endtask

task automatic wait_idle();
  do @(negedge clk); while (busy);
endtask

task automatic pulse_stat_clr();
  @(posedge clk);
  stat_clr <= 1'b1;
  @(posedge clk);
  stat_clr <= 1'b0;
  @(negedge clk);           // counters cleared by now
endtask

// ------------------------------------------------------------------------
// tests
// ------------------------------------------------------------------------
task automatic test_reset_state();
  @(negedge clk);
  check_count(int'(tx.valid), 0, "o_tx.valid");
  check_count(int'({tx.sop, tx.eop}), 0, "o_tx sop and eop");
  check_count(int'(busy), 0, "o_busy");
  check_stats(stats, '0);
endtask

task automatic test_single_packet();
  start_run(make_cfg(64, 64, 1, 1'b0, 0, pkt_gen_cfg_pkg::PAT_FIXED));
  wait_frames(1);
  check_count(run_beats, 2, "beats in a 64 byte packet");
  check_count(int'(busy), 0, "o_busy after eop");
endtask

task automatic test_size_sweep();
  start_run(make_cfg(65, 70, 9, 1'b0, 0, pkt_gen_cfg_pkg::PAT_INCR));
  wait_frames(9);
  check_count(int'(busy), 0, "o_busy after ninth eop");
  check_count(run_beats, 27, "beats in the sweep");
  repeat (8) @(negedge clk);
  check_count(run_frames, 9, "frames in the sweep");
endtask

task automatic test_back_pressure();
  @(posedge clk);
  ready_random <= 1'b1;
  start_run(make_cfg(65, 70, 9, 1'b0, 0, pkt_gen_cfg_pkg::PAT_INCR));
  wait_frames(9);
  check_count(int'(busy), 0, "o_busy after ninth eop");
  check_count(run_beats, 27, "beats under back-pressure");
  @(posedge clk);
  ready_random <= 1'b0;
endtask

// the monitor holds every sop to the configured gap
task automatic test_gap();
  start_run(make_cfg(64, 66, 4, 1'b0, 5, pkt_gen_cfg_pkg::PAT_INCR));
  wait_frames(4);
  check_count(int'(busy), 0, "o_busy after last eop");
endtask

task automatic test_continuous();
  start_run(make_cfg(100, 120, 0, 1'b1, 2, pkt_gen_cfg_pkg::PAT_INCR));
  // third packet is four beats long, stop lands in its middle
  do @(negedge clk); while (!(run_frames == 2 && in_frame));
  @(posedge clk);
  stop <= 1'b1;
  @(posedge clk);
  stop <= 1'b0;
  wait_idle();
  check_count(run_frames, 3, "frames after stop");
  check_count(int'(in_frame), 0, "frame left open after stop");
  repeat (20) @(negedge clk);
  check_count(run_sops, 3, "sop beats after stop");
  check_count(int'(busy), 0, "o_busy after stop");
endtask

task automatic test_stats();
  pkt_gen_cfg_pkg::tx_stats_t exp;
  pulse_stat_clr();
  check_stats(stats, '0);
  start_run(make_cfg(64, 66, 3, 1'b0, 1, pkt_gen_cfg_pkg::PAT_FIXED));
  wait_frames(3);
  wait_idle();
  exp.sop_cnt  = 16'(sop_total);
  exp.eop_cnt  = 16'(eop_total);
  exp.byte_cnt = 32'(byte_total);
  check_stats(stats, exp);
  check_count(byte_total, 64 + 65 + 66, "bytes seen by the monitor");
  pulse_stat_clr();
  check_stats(stats, '0);
endtask

/* tb_pkt_gen.sv */
/*
  Testbench for the Ethernet test-packet generator.
  Clock, reset, DUT, frame monitor, compare tasks and run timeout.
*/
`default_nettype none

module tb_pkt_gen;
  timeunit 1ns;
  timeprecision 100ps;

  // beats and gaps per test: reset, single, sweep, back-pressure, gap, continuous, stats
  localparam int TEST_CYCLES =
    2 + 2 + 9 * 3 + 9 * 3 + 4 * (3 + 5) + (3 * (4 + 2) + 20) + 3 * (3 + 1);
  localparam int CYCLE_LIMIT = 16 + 4 * (TEST_CYCLES + 7 * 12);  // x4 for back-pressure

  logic                        clk;
  logic                        rst;
  pkt_gen_cfg_pkg::pkt_cfg_t   cfg;
  logic                        start;
  logic                        stop;
  logic                        stat_clr;
  logic                        tx_ready;
  logic                        ready_random;   // random ready when set
  eth_frame_pkg::tx_beat_t     tx;
  logic                        busy;
  pkt_gen_cfg_pkg::tx_stats_t  stats;

  integer seed = 83;
  int     cycle_cnt = 0;

  // monitor state
  logic [7:0]   ready_hist;   // bit 0 holds the ready of the last cycle
  logic [127:0] hdr;          // first 16 bytes of the current frame
  logic         in_frame;
  logic         seen_eop;
  int           run_frames;
  int           run_sops;
  int           run_beats;
  int           beat_no;
  int           last_eop_cyc;
  int           sop_total;
  int           eop_total;
  int           byte_total;

  pkt_gen_top dut0 (
    .i_clk_tx   (clk),
    .i_reset    (rst),
    .i_cfg      (cfg),
    .i_start    (start),
    .i_stop     (stop),
    .i_stat_clr (stat_clr),
    .i_tx_ready (tx_ready),
    .o_tx       (tx),
    .o_busy     (busy),
    .o_stats    (stats)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    logic [31:0] rnd;
    tx_ready = 1'b0;
    forever begin
      @(posedge clk);
      rnd = $random(seed);
      tx_ready <= ready_random ? rnd[0] : 1'b1;
    end
  end

  initial begin
    forever begin
      @(posedge clk);
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= CYCLE_LIMIT) begin
        abort_run($sformatf("timeout after %0d cycles, the DUT never finished", cycle_cnt));
      end
    end
  end

  // ------------------------------------------------------------------------
  // compare tasks
  // ------------------------------------------------------------------------
  task automatic abort_run(string why);
    $display("%s", why);
    $display(">>> FAIL");
    $fatal(1, "run stopped at cycle %0d", cycle_cnt);
  endtask

  task automatic check_beat(eth_frame_pkg::tx_beat_t got, eth_frame_pkg::tx_beat_t exp);
    if (got !== exp) begin
      abort_run($sformatf("mismatch o_tx: got %h exp %h", got, exp));
    end
  endtask

  task automatic check_stats(pkt_gen_cfg_pkg::tx_stats_t got, pkt_gen_cfg_pkg::tx_stats_t exp);
    if (got !== exp) begin
      abort_run($sformatf("mismatch o_stats: got %h exp %h", got, exp));
    end
  endtask

  task automatic check_frame_field(logic [eth_frame_pkg::MAC_W-1:0] got,
                                   logic [eth_frame_pkg::MAC_W-1:0] exp, string name);
    if (got !== exp) begin
      abort_run($sformatf("mismatch %s: got %h exp %h", name, got, exp));
    end
  endtask

  task automatic check_count(int got, int exp, string name);
    if (got != exp) begin
      abort_run($sformatf("mismatch %s: got %h exp %h", name, got, exp));
    end
  endtask

  // ------------------------------------------------------------------------
  // frame model
  // ------------------------------------------------------------------------
  function automatic int size_of_frame(int n);
    return int'(cfg.start_size) + n % (int'(cfg.end_size) - int'(cfg.start_size) + 1);
  endfunction

  function automatic eth_frame_pkg::tx_beat_t model_beat(int beat, int idx, int size);
    eth_frame_pkg::tx_beat_t b;
    logic [127:0]            head;
    int                      off;
    head    = {cfg.dmac, cfg.smac, 16'(size), 16'(idx)};
    b       = '0;
    b.valid = 1'b1;
    b.sop   = (beat == 0);
    b.eop   = (beat == (size - 1) / 32);
    b.empty = b.eop ? 5'((32 - size % 32) % 32) : 5'd0;
    for (int i = 0; i < 32; i++) begin
      off = beat * 32 + i;
      if (off < 16) begin
        b.data[i / 8][63 - 8 * (i % 8) -: 8] = head[127 - 8 * off -: 8];
      end else if (cfg.pattern == pkt_gen_cfg_pkg::PAT_FIXED) begin
        b.data[i / 8][63 - 8 * (i % 8) -: 8] = 8'hA5;
      end else begin
        b.data[i / 8][63 - 8 * (i % 8) -: 8] = 8'(off);   // offset mod 256
      end
    end
    return b;
  endfunction

  task automatic take_beat();
    int size;
    int len;
    size = size_of_frame(run_frames);
    if (tx.sop) begin
      if (in_frame) abort_run("sop arrived before the previous frame ended");
      if (seen_eop) begin
        if (cycle_cnt - last_eop_cyc - 1 < int'(cfg.ipg_cycles)) begin
          abort_run($sformatf("only %0d idle cycles before sop", cycle_cnt - last_eop_cyc - 1));
        end
      end
      in_frame = 1'b1;
      beat_no  = 0;
      hdr      = {tx.data[0], tx.data[1]};
      check_frame_field(hdr[127:80], cfg.dmac, "dmac");
      check_frame_field(hdr[79:32], cfg.smac, "smac");
      check_frame_field(48'(hdr[31:16]), 48'(size), "header size");
      check_frame_field(48'(hdr[15:0]), 48'(16'(run_frames)), "packet index");
      run_sops++;
      sop_total++;
    end
    if (!in_frame) abort_run("valid beat outside of a frame");
    if (tx.eop) begin
      len = (beat_no + 1) * 32 - int'(tx.empty);
      check_frame_field(48'(len), 48'(size), "frame length");
    end
    check_beat(tx, model_beat(beat_no, run_frames, size));
    run_beats++;
    if (tx.eop) begin
      eop_total++;
      byte_total   += len;
      run_frames++;
      in_frame     = 1'b0;
      seen_eop     = 1'b1;
      last_eop_cyc = cycle_cnt;
    end else begin
      beat_no++;
    end
  endtask

  // ------------------------------------------------------------------------
  // monitor
  // ------------------------------------------------------------------------
  always @(posedge clk) begin
    if (rst) begin
      ready_hist = '0;
      in_frame   = 1'b0;
      seen_eop   = 1'b0;
      run_frames = 0;
      run_sops   = 0;
      run_beats  = 0;
      beat_no    = 0;
      sop_total  = 0;
      eop_total  = 0;
      byte_total = 0;
    end else begin
      if (tx.valid && !ready_hist[pkt_gen_cfg_pkg::READY_LATENCY-1]) begin
        abort_run("o_tx valid without i_tx_ready in the matching earlier cycle");
      end
      if (start) begin   // new run restarts the frame numbering
        run_frames = 0;
        run_sops   = 0;
        run_beats  = 0;
        seen_eop   = 1'b0;
      end
      if (tx.valid) take_beat();
      if (stat_clr) begin
        sop_total  = 0;
        eop_total  = 0;
        byte_total = 0;
      end
      ready_hist = {ready_hist[6:0], tx_ready};
    end
  end

  `include "tb_pkt_gen_tests.svh"

  initial begin
    rst          = 1'b1;
    cfg          = '0;
    start        = 1'b0;
    stop         = 1'b0;
    stat_clr     = 1'b0;
    ready_random = 1'b0;
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    test_reset_state();
    test_single_packet();
    test_size_sweep();
    test_back_pressure();
    test_gap();
    test_continuous();
    test_stats();
    $display(">>> PASS");
    $finish;
  end

endmodule : tb_pkt_gen

`default_nettype wire

/* tx_beat_drain.sv */
/*
  Transmit beat drain. Packs the lanes into the output beat, works out
  empty on eop and keeps the transmit sop, eop and byte counters.
*/
`default_nettype none

module tx_beat_drain (
  input  wire logic                                       i_clk_tx,
  input  wire logic                                       i_reset,
  input  wire pkt_gen_cfg_pkg::beat_ctl_t                 i_ctl,
  input  wire eth_frame_pkg::lane_t [0:eth_frame_pkg::LANES-1] i_lanes,
  input  wire logic                                       i_stat_clr,
  output eth_frame_pkg::tx_beat_t                         o_tx,
  output pkt_gen_cfg_pkg::tx_stats_t                      o_stats
);

  logic [eth_frame_pkg::EMPTY_W-1:0] size_rem;   // bytes in a partial last beat
  logic [eth_frame_pkg::EMPTY_W-1:0] last_empty;

  // ------------------------------------------------------------------------
  // output beat
  // ------------------------------------------------------------------------
  assign size_rem = i_ctl.size[eth_frame_pkg::EMPTY_W-1:0];

  // 32 minus the remainder; a full last beat wraps to zero
  assign last_empty = eth_frame_pkg::EMPTY_W'(eth_frame_pkg::BEAT_BYTES - int'(size_rem));

  always_comb begin
    o_tx.valid = i_ctl.valid;
    o_tx.sop   = i_ctl.sop;
    o_tx.eop   = i_ctl.eop;
    o_tx.empty = i_ctl.eop ? last_empty : '0;
    o_tx.data  = i_lanes;
  end

  // ------------------------------------------------------------------------
  // transmit counters
  // ------------------------------------------------------------------------
  always_ff @(posedge i_clk_tx) begin
    if (i_reset || i_stat_clr) begin
      o_stats <= '0;
    end else begin
      if (i_ctl.sop) begin
        o_stats.sop_cnt <= o_stats.sop_cnt + 16'd1;
      end
      if (i_ctl.eop) begin
        o_stats.eop_cnt  <= o_stats.eop_cnt + 16'd1;
        o_stats.byte_cnt <= o_stats.byte_cnt + 32'(i_ctl.size);  // whole packet at once
      end
    end
  end

  a_empty_eop_only: assert property (@(posedge i_clk_tx) disable iff (i_reset)
    (o_tx.valid && !o_tx.eop) |-> (o_tx.empty == '0));

endmodule : tx_beat_drain

`default_nettype wire
